/* hw/dispatch_pkg.sv */
package dispatch_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS = 32;
    localparam int DATA_W_DEFAULT = 32;

    // Operation code from decode
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_SHIFT,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_CSR_RD,
        OP_CSR_WR,
        OP_CSR_XCHG,
        OP_ERTN,
        OP_SYSCALL,
        OP_BREAK,
        OP_TLBRD,
        OP_TLBSRCH,
        OP_NOP
    } alu_op_e;

    // Result class that picks the execute unit
    typedef enum logic [2:0] {
        SEL_ARITH,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_LOAD_STORE,
        SEL_BRANCH,
        SEL_CSR,
        SEL_NONE
    } alu_sel_e;

    // System opcode classes that restrict pairing
    function automatic logic is_csr_op(alu_op_e op);
        return op inside {OP_CSR_RD, OP_CSR_WR, OP_CSR_XCHG};
    endfunction

    function automatic logic is_trap_op(alu_op_e op);
        return op inside {OP_ERTN, OP_SYSCALL, OP_BREAK};
    endfunction

    function automatic logic is_tlb_op(alu_op_e op);
        return op inside {OP_TLBRD, OP_TLBSRCH};
    endfunction

endpackage

/* hw/regfile.sv */
`timescale 1ns/1ps

module regfile import dispatch_pkg::*; #(
    parameter int DATA_W = DATA_W_DEFAULT
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // Four read ports, two per dispatch slot
    input  logic [3:0][REG_ADDR_W-1:0]  rd_addr_i,
    output logic [3:0][DATA_W-1:0]      rd_data_o,

    // Write-back ports
    input  logic [1:0]                  wb_we_i,
    input  logic [1:0][REG_ADDR_W-1:0]  wb_addr_i,
    input  logic [1:0][DATA_W-1:0]      wb_data_i
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    // Entry zero is only ever cleared and so stays zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 1; i < NUM_REGS; i++) begin
                // Port 1 wins on a shared address
                if (wb_we_i[1] && wb_addr_i[1] == REG_ADDR_W'(i)) begin
                    regs[i] <= wb_data_i[1];
                end else if (wb_we_i[0] && wb_addr_i[0] == REG_ADDR_W'(i)) begin
                    regs[i] <= wb_data_i[0];
                end
            end
        end
    end

    // Same-cycle writes reach the reads through the forward pipes
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rd_data_o[p] = regs[rd_addr_i[p]];
        end
    end

endmodule

/* hw/issue_arbiter.sv */
`timescale 1ns/1ps

module issue_arbiter import dispatch_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic [1:0]                       id_valid_i,
    input  alu_op_e [1:0]                    id_op_i,
    input  alu_sel_e [1:0]                   id_sel_i,
    input  logic [1:0][1:0]                  id_rs_valid_i,
    input  logic [1:0][1:0][REG_ADDR_W-1:0]  id_rs_addr_i,
    input  logic [1:0]                       id_rd_valid_i,
    input  logic [1:0][REG_ADDR_W-1:0]       id_rd_addr_i,

    input  logic                             stall_i,

    output logic [1:0]                       issue_mask_o,
    output logic [1:0]                       ib_accept_o,
    output logic                             stall_req_o
);

    logic raw_hazard;
    logic both_mem;
    logic both_csr;
    logic hold_slot1;

    // Slot 1 reads what slot 0 writes
    always_comb begin
        raw_hazard = 1'b0;
        for (int k = 0; k < 2; k++) begin
            if (id_rs_valid_i[1][k] && id_rd_valid_i[0] &&
                id_rs_addr_i[1][k] == id_rd_addr_i[0]) begin
                raw_hazard = 1'b1;
            end
        end
    end

    // Only one memory port and one CSR port downstream
    assign both_mem = (id_sel_i[0] == SEL_LOAD_STORE) && (id_sel_i[1] == SEL_LOAD_STORE);
    assign both_csr = is_csr_op(id_op_i[0]) && is_csr_op(id_op_i[1]);

    assign hold_slot1 = raw_hazard | both_mem | both_csr |
                        is_trap_op(id_op_i[1]) | is_tlb_op(id_op_i[1]);

    // Slot 0 always goes out
    assign issue_mask_o = {~hold_slot1, 1'b1};

    assign ib_accept_o = stall_i ? 2'b00 : (issue_mask_o & id_valid_i);

    // Advisory pulse for the controller's pairing counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_req_o <= 1'b0;
        end else begin
            stall_req_o <= id_valid_i[1] & hold_slot1;
        end
    end

endmodule

/* hw/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass import dispatch_pkg::*; #(
    parameter int DATA_W = DATA_W_DEFAULT
) (
    input  logic [1:0][1:0]                  id_rs_valid_i,
    input  logic [1:0][1:0][REG_ADDR_W-1:0]  id_rs_addr_i,
    input  logic [1:0][1:0][DATA_W-1:0]      rf_rdata_i,

    // Execute pipe results
    input  logic [1:0]                       ex_fwd_valid_i,
    input  logic [1:0][REG_ADDR_W-1:0]       ex_fwd_addr_i,
    input  logic [1:0][DATA_W-1:0]           ex_fwd_data_i,

    // Memory pipe results
    input  logic [1:0]                       mem_fwd_valid_i,
    input  logic [1:0][REG_ADDR_W-1:0]       mem_fwd_addr_i,
    input  logic [1:0][DATA_W-1:0]           mem_fwd_data_i,

    output logic [1:0][1:0][DATA_W-1:0]      src_o
);

    logic [1:0][1:0] rs_live;

    // A source takes part only when read and not register zero
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 2; k++) begin
                rs_live[s][k] = id_rs_valid_i[s][k] && (id_rs_addr_i[s][k] != '0);
            end
        end
    end

    // Matches applied in the order mem 0, mem 1, ex 0, ex 1 so the youngest lands last
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 2; k++) begin
                src_o[s][k] = rf_rdata_i[s][k];
                for (int m = 0; m < 2; m++) begin
                    if (rs_live[s][k] && mem_fwd_valid_i[m] &&
                        mem_fwd_addr_i[m] == id_rs_addr_i[s][k]) begin
                        src_o[s][k] = mem_fwd_data_i[m];
                    end
                end
                for (int e = 0; e < 2; e++) begin
                    if (rs_live[s][k] && ex_fwd_valid_i[e] &&
                        ex_fwd_addr_i[e] == id_rs_addr_i[s][k]) begin
                        src_o[s][k] = ex_fwd_data_i[e];
                    end
                end
            end
        end
    end

endmodule

/* hw/dispatch_reg.sv */
`timescale 1ns/1ps

module dispatch_reg import dispatch_pkg::*; #(
    parameter int DATA_W = DATA_W_DEFAULT
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             stall_i,
    input  logic                             flush_i,
    input  logic [1:0]                       issue_mask_i,

    input  logic [1:0]                       id_valid_i,
    input  alu_op_e [1:0]                    id_op_i,
    input  alu_sel_e [1:0]                   id_sel_i,
    input  logic [1:0][1:0]                  id_rs_valid_i,
    input  logic [1:0][1:0][REG_ADDR_W-1:0]  id_rs_addr_i,
    input  logic [1:0]                       id_rd_valid_i,
    input  logic [1:0][REG_ADDR_W-1:0]       id_rd_addr_i,
    input  logic [1:0]                       id_use_imm_i,
    input  logic [1:0][DATA_W-1:0]           id_imm_i,
    input  logic [1:0][1:0][DATA_W-1:0]      src_i,

    output logic [1:0]                       exe_valid_o,
    output alu_op_e [1:0]                    exe_op_o,
    output alu_sel_e [1:0]                   exe_sel_o,
    output logic [1:0]                       exe_rd_valid_o,
    output logic [1:0][REG_ADDR_W-1:0]       exe_rd_addr_o,
    output logic [1:0][DATA_W-1:0]           exe_src1_o,
    output logic [1:0][DATA_W-1:0]           exe_src2_o,
    output logic [1:0][DATA_W-1:0]           exe_imm_o,
    output logic [1:0][1:0][REG_ADDR_W-1:0]  exe_rs_addr_o
);

    logic [1:0] load;

    assign load = id_valid_i & issue_mask_i;

    for (genvar s = 0; s < 2; s++) begin : g_slot
        // Control bits where stall wins over flush
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                exe_valid_o[s]    <= 1'b0;
                exe_rd_valid_o[s] <= 1'b0;
            end else if (!stall_i) begin
                exe_valid_o[s]    <= load[s] & ~flush_i;
                exe_rd_valid_o[s] <= load[s] & ~flush_i & id_rd_valid_i[s];
            end
        end

        always_ff @(posedge clk) begin
            if (!stall_i) begin
                if (flush_i || !load[s]) begin
                    exe_op_o[s]      <= OP_NOP;
                    exe_sel_o[s]     <= SEL_NONE;
                    exe_rd_addr_o[s] <= '0;
                    exe_src1_o[s]    <= '0;
                    exe_src2_o[s]    <= '0;
                    exe_imm_o[s]     <= '0;
                    exe_rs_addr_o[s] <= '0;
                end else begin
                    exe_op_o[s]      <= id_op_i[s];
                    exe_sel_o[s]     <= id_sel_i[s];
                    exe_rd_addr_o[s] <= id_rd_addr_i[s];
                    exe_src1_o[s]    <= src_i[s][0];
                    // Immediate replaces the second operand
                    exe_src2_o[s]    <= id_use_imm_i[s] ? id_imm_i[s] : src_i[s][1];
                    exe_imm_o[s]     <= id_imm_i[s];
                    for (int k = 0; k < 2; k++) begin
                        exe_rs_addr_o[s][k] <= id_rs_valid_i[s][k] ? id_rs_addr_i[s][k] : '0;
                    end
                end
            end
        end
    end

endmodule

/* hw/dispatch_top.sv */
`timescale 1ns/1ps

module dispatch_top import dispatch_pkg::*; #(
    parameter int DATA_W = DATA_W_DEFAULT
) (
    input  logic                             clk,
    input  logic                             rst_n,

    // Instruction buffer slots
    input  logic [1:0]                       id_valid_i,
    input  alu_op_e [1:0]                    id_op_i,
    input  alu_sel_e [1:0]                   id_sel_i,
    input  logic [1:0][1:0]                  id_rs_valid_i,
    input  logic [1:0][1:0][REG_ADDR_W-1:0]  id_rs_addr_i,
    input  logic [1:0]                       id_rd_valid_i,
    input  logic [1:0][REG_ADDR_W-1:0]       id_rd_addr_i,
    input  logic [1:0]                       id_use_imm_i,
    input  logic [1:0][DATA_W-1:0]           id_imm_i,
    output logic [1:0]                       ib_accept_o,

    // Pipeline controller
    input  logic                             stall_i,
    input  logic                             flush_i,
    output logic                             stall_req_o,

    // Forwarding from execute and memory
    input  logic [1:0]                       ex_fwd_valid_i,
    input  logic [1:0][REG_ADDR_W-1:0]       ex_fwd_addr_i,
    input  logic [1:0][DATA_W-1:0]           ex_fwd_data_i,
    input  logic [1:0]                       mem_fwd_valid_i,
    input  logic [1:0][REG_ADDR_W-1:0]       mem_fwd_addr_i,
    input  logic [1:0][DATA_W-1:0]           mem_fwd_data_i,

    // Write-back
    input  logic [1:0]                       wb_we_i,
    input  logic [1:0][REG_ADDR_W-1:0]       wb_addr_i,
    input  logic [1:0][DATA_W-1:0]           wb_data_i,

    // Issued pair toward execute
    output logic [1:0]                       exe_valid_o,
    output alu_op_e [1:0]                    exe_op_o,
    output alu_sel_e [1:0]                   exe_sel_o,
    output logic [1:0]                       exe_rd_valid_o,
    output logic [1:0][REG_ADDR_W-1:0]       exe_rd_addr_o,
    output logic [1:0][DATA_W-1:0]           exe_src1_o,
    output logic [1:0][DATA_W-1:0]           exe_src2_o,
    output logic [1:0][DATA_W-1:0]           exe_imm_o,
    output logic [1:0][1:0][REG_ADDR_W-1:0]  exe_rs_addr_o
);

    logic [1:0]                    issue_mask;
    // Read port 2*slot+src
    logic [3:0][DATA_W-1:0]        rf_rdata;
    logic [1:0][1:0][DATA_W-1:0]   src_ops;

    regfile #(.DATA_W(DATA_W)) u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_i (id_rs_addr_i),
        .rd_data_o (rf_rdata),
        .wb_we_i   (wb_we_i),
        .wb_addr_i (wb_addr_i),
        .wb_data_i (wb_data_i)
    );

    issue_arbiter u_issue_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_valid_i    (id_valid_i),
        .id_op_i       (id_op_i),
        .id_sel_i      (id_sel_i),
        .id_rs_valid_i (id_rs_valid_i),
        .id_rs_addr_i  (id_rs_addr_i),
        .id_rd_valid_i (id_rd_valid_i),
        .id_rd_addr_i  (id_rd_addr_i),
        .stall_i       (stall_i),
        .issue_mask_o  (issue_mask),
        .ib_accept_o   (ib_accept_o),
        .stall_req_o   (stall_req_o)
    );

    operand_bypass #(.DATA_W(DATA_W)) u_operand_bypass (
        .id_rs_valid_i   (id_rs_valid_i),
        .id_rs_addr_i    (id_rs_addr_i),
        .rf_rdata_i      (rf_rdata),
        .ex_fwd_valid_i  (ex_fwd_valid_i),
        .ex_fwd_addr_i   (ex_fwd_addr_i),
        .ex_fwd_data_i   (ex_fwd_data_i),
        .mem_fwd_valid_i (mem_fwd_valid_i),
        .mem_fwd_addr_i  (mem_fwd_addr_i),
        .mem_fwd_data_i  (mem_fwd_data_i),
        .src_o           (src_ops)
    );

    dispatch_reg #(.DATA_W(DATA_W)) u_dispatch_reg (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .issue_mask_i   (issue_mask),
        .id_valid_i     (id_valid_i),
        .id_op_i        (id_op_i),
        .id_sel_i       (id_sel_i),
        .id_rs_valid_i  (id_rs_valid_i),
        .id_rs_addr_i   (id_rs_addr_i),
        .id_rd_valid_i  (id_rd_valid_i),
        .id_rd_addr_i   (id_rd_addr_i),
        .id_use_imm_i   (id_use_imm_i),
        .id_imm_i       (id_imm_i),
        .src_i          (src_ops),
        .exe_valid_o    (exe_valid_o),
        .exe_op_o       (exe_op_o),
        .exe_sel_o      (exe_sel_o),
        .exe_rd_valid_o (exe_rd_valid_o),
        .exe_rd_addr_o  (exe_rd_addr_o),
        .exe_src1_o     (exe_src1_o),
        .exe_src2_o     (exe_src2_o),
        .exe_imm_o      (exe_imm_o),
        .exe_rs_addr_o  (exe_rs_addr_o)
    );

endmodule

/* dv/dispatch_tb_tasks.svh */
task automatic check_data(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_op(string name, alu_op_e got, alu_op_e exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_sel(string name, alu_sel_e got, alu_sel_e exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_mask(string name, logic [1:0] got, logic [1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic report_test(string name, int err_start);
    tests_run++;
    if (errors == err_start) begin
        $display("[%s] ok", name);
    end else begin
        $display("[%s] FAILED with %0d errors", name, errors - err_start);
    end
endtask

task automatic clear_inputs();
    id_valid_i <= '0;
    for (int s = 0; s < 2; s++) begin
        id_op_i[s] <= OP_NOP;
        id_sel_i[s] <= SEL_NONE;
    end
    id_rs_valid_i <= '0;
    id_rs_addr_i <= '0;
    id_rd_valid_i <= '0;
    id_rd_addr_i <= '0;
    id_use_imm_i <= '0;
    id_imm_i <= '0;
    stall_i <= 1'b0;
    flush_i <= 1'b0;
    ex_fwd_valid_i <= '0;
    ex_fwd_addr_i <= '0;
    ex_fwd_data_i <= '0;
    mem_fwd_valid_i <= '0;
    mem_fwd_addr_i <= '0;
    mem_fwd_data_i <= '0;
    wb_we_i <= '0;
    wb_addr_i <= '0;
    wb_data_i <= '0;
endtask

task automatic new_cycle();
    @(posedge clk);
    clear_inputs();
endtask

task automatic set_slot(int s, alu_op_e op, alu_sel_e sel, logic [1:0] rs_v,
                        logic [4:0] rs0, logic [4:0] rs1, logic rd_v, logic [4:0] rd);
    id_valid_i[s] <= 1'b1;
    id_op_i[s] <= op;
    id_sel_i[s] <= sel;
    id_rs_valid_i[s] <= rs_v;
    id_rs_addr_i[s][0] <= rs0;
    id_rs_addr_i[s][1] <= rs1;
    id_rd_valid_i[s] <= rd_v;
    id_rd_addr_i[s] <= rd;
    id_imm_i[s] <= DATA_W'(next_rand());
endtask

// en bits are ex1, ex0, mem1, mem0
task automatic set_forward(logic [3:0] en, logic [4:0] addr);
    ex_fwd_valid_i <= en[3:2];
    mem_fwd_valid_i <= en[1:0];
    for (int p = 0; p < 2; p++) begin
        ex_fwd_addr_i[p] <= addr;
        mem_fwd_addr_i[p] <= addr;
        ex_fwd_data_i[p] <= DATA_W'(next_rand());
        mem_fwd_data_i[p] <= DATA_W'(next_rand());
    end
endtask

task automatic write_pair(logic [4:0] a0, logic [DATA_W-1:0] d0,
                          logic [4:0] a1, logic [DATA_W-1:0] d1);
    @(posedge clk);
    wb_we_i <= 2'b11;
    wb_addr_i[0] <= a0;
    wb_addr_i[1] <= a1;
    wb_data_i[0] <= d0;
    wb_data_i[1] <= d1;
    @(posedge clk);
    wb_we_i <= 2'b00;
    // Port 1 lands last and register zero never changes
    if (a0 != '0) begin
        shadow[a0] = d0;
    end
    if (a1 != '0) begin
        shadow[a1] = d1;
    end
endtask

task automatic predict_outputs(logic [1:0] accept);
    for (int s = 0; s < 2; s++) begin
        exp_valid[s] = accept[s] && !flush_i;
        exp_rd_valid[s] = exp_valid[s] && id_rd_valid_i[s];
        if (exp_valid[s]) begin
            exp_op[s] = id_op_i[s];
            exp_sel[s] = id_sel_i[s];
            exp_rd_addr[s] = id_rd_addr_i[s];
            exp_src1[s] = expect_operand(s, 0);
            exp_src2[s] = id_use_imm_i[s] ? id_imm_i[s] : expect_operand(s, 1);
            exp_imm[s] = id_imm_i[s];
            for (int k = 0; k < 2; k++) begin
                exp_rs_addr[s][k] = id_rs_valid_i[s][k] ? id_rs_addr_i[s][k] : '0;
            end
        end
    end
endtask

task automatic check_outputs();
    check_mask("exe_valid_o", exe_valid_o, exp_valid);
    check_mask("exe_rd_valid_o", exe_rd_valid_o, exp_rd_valid);
    for (int s = 0; s < 2; s++) begin
        if (exp_valid[s]) begin
            check_op($sformatf("exe_op_o[%0d]", s), exe_op_o[s], exp_op[s]);
            check_sel($sformatf("exe_sel_o[%0d]", s), exe_sel_o[s], exp_sel[s]);
            check_data($sformatf("exe_rd_addr_o[%0d]", s),
                       DATA_W'(exe_rd_addr_o[s]), DATA_W'(exp_rd_addr[s]));
            check_data($sformatf("exe_src1_o[%0d]", s), exe_src1_o[s], exp_src1[s]);
            check_data($sformatf("exe_src2_o[%0d]", s), exe_src2_o[s], exp_src2[s]);
            check_data($sformatf("exe_imm_o[%0d]", s), exe_imm_o[s], exp_imm[s]);
            for (int k = 0; k < 2; k++) begin
                check_data($sformatf("exe_rs_addr_o[%0d][%0d]", s, k),
                           DATA_W'(exe_rs_addr_o[s][k]), DATA_W'(exp_rs_addr[s][k]));
            end
        end
    end
endtask

// Accept mask checked before the edge and exe outputs one clock later
task automatic issue_cycle(logic [1:0] exp_accept);
    @(negedge clk);
    check_mask("ib_accept_o", ib_accept_o, exp_accept);
    if (!stall_i) begin
        predict_outputs(exp_accept);
    end
    @(posedge clk);
    @(negedge clk);
    check_outputs();
endtask

// All pairing cases have a valid slot 1
task automatic check_pairing(logic [1:0] exp_accept);
    issue_cycle(exp_accept);
    check_mask("stall_req_o", {1'b0, stall_req_o}, {1'b0, ~exp_accept[1]});
endtask

task automatic test_reset_writeback();
    int err_start;
    logic [31:0] r;
    err_start = errors;
    @(negedge clk);
    check_mask("exe_valid_o", exe_valid_o, 2'b00);
    check_mask("exe_rd_valid_o", exe_rd_valid_o, 2'b00);
    check_mask("stall_req_o", {1'b0, stall_req_o}, 2'b00);
    for (int i = 0; i < 12; i++) begin
        r = next_rand();
        write_pair(r[4:0], DATA_W'(next_rand()), r[12:8], DATA_W'(next_rand()));
    end
    write_pair(5'd20, DATA_W'(next_rand()), 5'd20, DATA_W'(next_rand()));
    write_pair(5'd0, DATA_W'(next_rand()), 5'd0, DATA_W'(next_rand()));
    for (int base = 0; base < NUM_REGS; base += 4) begin
        new_cycle();
        set_slot(0, OP_ADD, SEL_ARITH, 2'b11, 5'(base), 5'(base + 1), 1'b0, 5'd0);
        set_slot(1, OP_OR, SEL_LOGIC, 2'b11, 5'(base + 2), 5'(base + 3), 1'b0, 5'd0);
        issue_cycle(2'b11);
    end
    report_test("reset_writeback", err_start);
endtask

task automatic test_pairing();
    int err_start;
    alu_op_e sys_ops [5];
    err_start = errors;
    sys_ops = '{OP_ERTN, OP_SYSCALL, OP_BREAK, OP_TLBRD, OP_TLBSRCH};
    // Read after write inside the pair
    new_cycle();
    set_slot(0, OP_ADD, SEL_ARITH, 2'b11, 5'd1, 5'd2, 1'b1, 5'd3);
    set_slot(1, OP_SUB, SEL_ARITH, 2'b10, 5'd0, 5'd3, 1'b1, 5'd4);
    check_pairing(2'b01);
    new_cycle();
    set_slot(0, OP_LOAD, SEL_LOAD_STORE, 2'b01, 5'd5, 5'd0, 1'b1, 5'd6);
    set_slot(1, OP_STORE, SEL_LOAD_STORE, 2'b11, 5'd7, 5'd8, 1'b0, 5'd0);
    check_pairing(2'b01);
    new_cycle();
    set_slot(0, OP_CSR_RD, SEL_CSR, 2'b00, 5'd0, 5'd0, 1'b1, 5'd9);
    set_slot(1, OP_CSR_WR, SEL_CSR, 2'b01, 5'd10, 5'd0, 1'b0, 5'd0);
    check_pairing(2'b01);
    for (int i = 0; i < 5; i++) begin
        new_cycle();
        set_slot(0, OP_ADD, SEL_ARITH, 2'b01, 5'd11, 5'd0, 1'b1, 5'd12);
        set_slot(1, sys_ops[i], SEL_NONE, 2'b00, 5'd0, 5'd0, 1'b0, 5'd0);
        check_pairing(2'b01);
    end
    new_cycle();
    set_slot(0, OP_AND, SEL_LOGIC, 2'b11, 5'd13, 5'd14, 1'b1, 5'd15);
    set_slot(1, OP_SHIFT, SEL_SHIFT, 2'b11, 5'd16, 5'd17, 1'b1, 5'd18);
    check_pairing(2'b11);
    report_test("pairing", err_start);
endtask

task automatic test_forwarding();
    int err_start;
    err_start = errors;
    // Drop the highest priority port one at a time
    for (int i = 0; i < 5; i++) begin
        new_cycle();
        set_forward(4'b1111 >> i, 5'd9);
        set_slot(0, OP_ADD, SEL_ARITH, 2'b11, 5'd9, 5'd10, 1'b0, 5'd0);
        set_slot(1, OP_SUB, SEL_ARITH, 2'b10, 5'd9, 5'd9, 1'b0, 5'd0);
        issue_cycle(2'b11);
    end
    new_cycle();
    set_forward(4'b1111, 5'd0);
    set_slot(0, OP_ADD, SEL_ARITH, 2'b11, 5'd0, 5'd0, 1'b0, 5'd0);
    set_slot(1, OP_OR, SEL_LOGIC, 2'b01, 5'd0, 5'd0, 1'b0, 5'd0);
    issue_cycle(2'b11);
    check_data("exe_src1_o[0]", exe_src1_o[0], '0);
    report_test("forwarding", err_start);
endtask

task automatic test_imm_addr();
    int err_start;
    logic [DATA_W-1:0] imm;
    err_start = errors;
    imm = DATA_W'(next_rand());
    new_cycle();
    set_slot(0, OP_ADD, SEL_ARITH, 2'b01, 5'd11, 5'd12, 1'b1, 5'd13);
    set_slot(1, OP_BRANCH, SEL_BRANCH, 2'b00, 5'd14, 5'd15, 1'b0, 5'd0);
    id_use_imm_i[0] <= 1'b1;
    id_imm_i[0] <= imm;
    issue_cycle(2'b11);
    check_data("exe_src2_o[0]", exe_src2_o[0], imm);
    check_data("exe_rs_addr_o[0][1]", DATA_W'(exe_rs_addr_o[0][1]), '0);
    report_test("imm_addr", err_start);
endtask

task automatic test_stall_flush();
    int err_start;
    err_start = errors;
    new_cycle();
    set_slot(0, OP_ADD, SEL_ARITH, 2'b11, 5'd1, 5'd2, 1'b1, 5'd20);
    set_slot(1, OP_OR, SEL_LOGIC, 2'b11, 5'd3, 5'd4, 1'b1, 5'd21);
    issue_cycle(2'b11);
    // New pair offered while stall holds the outputs
    new_cycle();
    stall_i <= 1'b1;
    set_slot(0, OP_SUB, SEL_ARITH, 2'b11, 5'd5, 5'd6, 1'b1, 5'd22);
    set_slot(1, OP_AND, SEL_LOGIC, 2'b11, 5'd7, 5'd8, 1'b1, 5'd23);
    issue_cycle(2'b00);
    @(posedge clk);
    flush_i <= 1'b1;
    issue_cycle(2'b00);
    // Flush alone empties the stage
    @(posedge clk);
    stall_i <= 1'b0;
    issue_cycle(2'b11);
    report_test("stall_flush", err_start);
endtask

/* dv/dispatch_tb.sv */
`timescale 1ns/1ps

module dispatch_tb import dispatch_pkg::*; ();

    localparam int DATA_W = 32;
    // Cycle budget of the directed tests, doubled for the watchdog
    localparam int TEST_CYCLES = 1000;
    localparam int MAX_CYCLES = 2 * TEST_CYCLES;

    logic clk = 1'b0;
    logic rst_n;

    // DUT ports
    logic [1:0]                      id_valid_i;
    alu_op_e [1:0]                   id_op_i;
    alu_sel_e [1:0]                  id_sel_i;
    logic [1:0][1:0]                 id_rs_valid_i;
    logic [1:0][1:0][REG_ADDR_W-1:0] id_rs_addr_i;
    logic [1:0]                      id_rd_valid_i;
    logic [1:0][REG_ADDR_W-1:0]      id_rd_addr_i;
    logic [1:0]                      id_use_imm_i;
    logic [1:0][DATA_W-1:0]          id_imm_i;
    logic [1:0]                      ib_accept_o;
    logic                            stall_i;
    logic                            flush_i;
    logic                            stall_req_o;
    logic [1:0]                      ex_fwd_valid_i;
    logic [1:0][REG_ADDR_W-1:0]      ex_fwd_addr_i;
    logic [1:0][DATA_W-1:0]          ex_fwd_data_i;
    logic [1:0]                      mem_fwd_valid_i;
    logic [1:0][REG_ADDR_W-1:0]      mem_fwd_addr_i;
    logic [1:0][DATA_W-1:0]          mem_fwd_data_i;
    logic [1:0]                      wb_we_i;
    logic [1:0][REG_ADDR_W-1:0]      wb_addr_i;
    logic [1:0][DATA_W-1:0]          wb_data_i;
    logic [1:0]                      exe_valid_o;
    alu_op_e [1:0]                   exe_op_o;
    alu_sel_e [1:0]                  exe_sel_o;
    logic [1:0]                      exe_rd_valid_o;
    logic [1:0][REG_ADDR_W-1:0]      exe_rd_addr_o;
    logic [1:0][DATA_W-1:0]          exe_src1_o;
    logic [1:0][DATA_W-1:0]          exe_src2_o;
    logic [1:0][DATA_W-1:0]          exe_imm_o;
    logic [1:0][1:0][REG_ADDR_W-1:0] exe_rs_addr_o;

    // Predicted register file contents
    logic [DATA_W-1:0] shadow [NUM_REGS];

    // Expected outputs of the issued pair
    logic [1:0]                      exp_valid;
    logic [1:0]                      exp_rd_valid;
    alu_op_e [1:0]                   exp_op;
    alu_sel_e [1:0]                  exp_sel;
    logic [1:0][REG_ADDR_W-1:0]      exp_rd_addr;
    logic [1:0][DATA_W-1:0]          exp_src1;
    logic [1:0][DATA_W-1:0]          exp_src2;
    logic [1:0][DATA_W-1:0]          exp_imm;
    logic [1:0][1:0][REG_ADDR_W-1:0] exp_rs_addr;

    logic [31:0] rng_state = 32'he832;
    int cycle_cnt = 0;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;

    dispatch_top #(.DATA_W(DATA_W)) dut_i (.*);

    always #4 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: no end of test after %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Priority ex1, ex0, mem1, mem0, else the register file
    function automatic logic [DATA_W-1:0] expect_operand(int s, int k);
        logic [REG_ADDR_W-1:0] a;
        logic [DATA_W-1:0] v;
        a = id_rs_addr_i[s][k];
        v = shadow[a];
        if (id_rs_valid_i[s][k] && a != '0) begin
            if (ex_fwd_valid_i[1] && ex_fwd_addr_i[1] == a) begin
                v = ex_fwd_data_i[1];
            end else if (ex_fwd_valid_i[0] && ex_fwd_addr_i[0] == a) begin
                v = ex_fwd_data_i[0];
            end else if (mem_fwd_valid_i[1] && mem_fwd_addr_i[1] == a) begin
                v = mem_fwd_data_i[1];
            end else if (mem_fwd_valid_i[0] && mem_fwd_addr_i[0] == a) begin
                v = mem_fwd_data_i[0];
            end
        end
        return v;
    endfunction

    `include "dispatch_tb_tasks.svh"

    initial begin
        rst_n <= 1'b0;
        clear_inputs();
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_writeback();
        test_pairing();
        test_forwarding();
        test_imm_addr();
        test_stall_flush();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+dv
hw/dispatch_pkg.sv
hw/regfile.sv
hw/issue_arbiter.sv
hw/operand_bypass.sv
hw/dispatch_reg.sv
hw/dispatch_top.sv
dv/dispatch_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module dispatch_tb -f src.f -o dispatch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/dispatch_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF "All tests passed!"; then
    exit 0
fi
exit 1
